//--- hw/l1dPkg.sv
package l1dPkg;

	typedef logic [31:0] addrT;
	typedef logic [27:0] lineAddrT;	// address without the byte-in-line bits
	typedef logic [127:0] lineT;
	typedef logic [63:0] wordT;

	typedef enum logic [1:0] {kindNone, kindLoad, kindStore} accessKindT;
	typedef enum logic [1:0] {sizeByte, sizeHalf, sizeWord, sizeDouble} accessSizeT;

	// memory side opcode and status
	typedef enum logic [1:0] {opIdle, opReadLine, opWriteLine} memOpT;
	typedef enum logic [1:0] {okReady, okOk, okHold} memOkT;

	typedef struct packed {
		accessKindT kind;
		accessSizeT size;
		logic isUnsigned;
		addrT addr;
		wordT storeData;
	} coreReqT;

	typedef struct packed {
		logic valid;
		wordT loadData;	// zero for stores
	} coreRespT;

	typedef struct packed {
		memOpT op;
		addrT addr;
		lineT data;
	} memReqT;

	typedef struct packed {
		logic valid;
		logic dirty;
		lineAddrT lineAddr;
		lineT data;
	} bankEntryT;

	// bank picks its index out of lineAddr
	typedef struct packed {
		logic enable;
		logic dirty;
		lineAddrT lineAddr;
		lineT data;
	} bankWriteT;

endpackage

//--- hw/requestStage.sv
`timescale 1ns/1ps

module requestStage
	import l1dPkg::*;
(
	input logic clock,
	input logic arstN,
	input coreReqT coreReq,
	input logic stall,
	output coreReqT heldReq,
	output lineAddrT evenLine,
	output lineAddrT oddLine,
	output lineAddrT readEven,
	output lineAddrT readOdd
);
	coreReqT nextReq;

	// addressed line plus its upper neighbour, returned as {even, odd}
	function automatic logic [55:0] splitLines(addrT addr);
		lineAddrT base;
		lineAddrT above;
		base = addr[31:4];
		above = base + 28'd1;
		if (addr[4])
			return {above, base};
		return {base, above};
	endfunction

	assign nextReq = stall ? heldReq : coreReq;	// recirculate on stall

	assign {readEven, readOdd} = splitLines(nextReq.addr);
	assign {evenLine, oddLine} = splitLines(heldReq.addr);

	always_ff @(posedge clock or negedge arstN)
	begin
		if (!arstN)
			heldReq <= '0;	// kind none
		else
			heldReq <= nextReq;
	end

endmodule

//--- hw/cacheBank.sv
`timescale 1ns/1ps

module cacheBank
	import l1dPkg::*;
#(
	parameter int indexBits = 6
)(
	input logic clock,
	input logic arstN,
	input lineAddrT readLine,
	output bankEntryT entry,
	input bankWriteT write
);
	localparam int depth = 2 ** indexBits;
	typedef logic [indexBits-1:0] indexT;

	lineT dataMem [depth];
	lineAddrT tagMem [depth];
	logic [depth-1:0] validBits;
	logic [depth-1:0] dirtyBits;
	indexT readIdx;
	indexT writeIdx;
	logic lastParity;

	// bit 0 selects the bank, so the index starts above it
	assign readIdx = readLine[indexBits:1];
	assign writeIdx = write.lineAddr[indexBits:1];

	always_ff @(posedge clock or negedge arstN)
	begin
		if (!arstN)
		begin
			validBits <= '0;
			dirtyBits <= '0;
		end
		else if (write.enable)
		begin
			validBits[writeIdx] <= 1'b1;
			dirtyBits[writeIdx] <= write.dirty;
		end
	end

	always_ff @(posedge clock)
	begin
		if (write.enable)
		begin
			dataMem[writeIdx] <= write.data;
			tagMem[writeIdx] <= write.lineAddr;
		end
		entry <= '{valid: validBits[readIdx], dirty: dirtyBits[readIdx],
			lineAddr: tagMem[readIdx], data: dataMem[readIdx]};	// old data on collision
		lastParity <= readLine[0];
	end

	// each bank only ever sees lines of its own parity
	assert property (@(posedge clock) disable iff (!arstN)
		write.enable |-> write.lineAddr[0] == lastParity);

endmodule

//--- hw/accessStage.sv
`timescale 1ns/1ps

module accessStage
	import l1dPkg::*;
(
	input logic clock,
	input logic arstN,
	input coreReqT heldReq,
	input lineAddrT evenLine,
	input lineAddrT oddLine,
	input bankEntryT evenEntry,
	input bankEntryT oddEntry,
	input bankWriteT fillEven,
	input bankWriteT fillOdd,
	input logic busy,
	output logic missEven,
	output logic missOdd,
	output logic stall,
	output bankWriteT evenWrite,
	output bankWriteT oddWrite,
	output coreRespT coreResp
);
	bankWriteT lastEven;
	bankWriteT lastOdd;
	bankWriteT storeEven;
	bankWriteT storeOdd;
	bankEntryT evenFwd;
	bankEntryT oddFwd;
	logic active;
	logic doStore;
	logic needEven;
	logic needOdd;
	logic [2:0] lastOfs;
	logic [4:0] lastByte;
	logic [5:0] shift;
	wordT sizeMask;
	wordT raw;
	wordT loadValue;
	lineT loLine;
	lineT hiLine;
	lineT window;
	lineT merged;
	lineT newLo;
	lineT newHi;

	// entry read on the edge of our last write is stale
	function automatic bankEntryT forward(bankEntryT e, bankWriteT w, lineAddrT line);
		if (w.enable && w.lineAddr == line)
			return '{valid: 1'b1, dirty: w.dirty, lineAddr: w.lineAddr, data: w.data};
		return e;
	endfunction

	assign evenFwd = forward(evenEntry, lastEven, evenLine);
	assign oddFwd = forward(oddEntry, lastOdd, oddLine);

	always_comb
	begin
		case (heldReq.size)
			sizeByte: sizeMask = 64'hff;
			sizeHalf: sizeMask = 64'hffff;
			sizeWord: sizeMask = 64'hffff_ffff;
			default: sizeMask = '1;
		endcase
	end

	assign lastOfs = 3'((4'd1 << heldReq.size) - 4'd1);	// size in bytes minus one

	assign lastByte = {1'b0, heldReq.addr[3:0]} + {2'b00, lastOfs};
	assign needEven = ~heldReq.addr[4] | lastByte[4];	// bit 4 set means it spans
	assign needOdd = heldReq.addr[4] | lastByte[4];

	assign active = heldReq.kind != kindNone;
	assign missEven = active && needEven &&
		!(evenFwd.valid && evenFwd.lineAddr == evenLine);
	assign missOdd = active && needOdd &&
		!(oddFwd.valid && oddFwd.lineAddr == oddLine);
	assign stall = active && (missEven || missOdd || busy);

	assign loLine = heldReq.addr[4] ? oddFwd.data : evenFwd.data;
	assign hiLine = heldReq.addr[4] ? evenFwd.data : oddFwd.data;
	assign window = heldReq.addr[3] ? {hiLine[63:0], loLine[127:64]} : loLine;
	assign shift = {heldReq.addr[2:0], 3'b000};
	assign raw = wordT'(window >> shift);

	always_comb
	begin
		case (heldReq.size)
			sizeByte: loadValue = {{56{~heldReq.isUnsigned & raw[7]}}, raw[7:0]};
			sizeHalf: loadValue = {{48{~heldReq.isUnsigned & raw[15]}}, raw[15:0]};
			sizeWord: loadValue = {{32{~heldReq.isUnsigned & raw[31]}}, raw[31:0]};
			default: loadValue = raw;
		endcase
	end

	// store bytes dropped into the window, then split back into lines
	assign merged = (window & ~(lineT'(sizeMask) << shift)) |
		(lineT'(heldReq.storeData & sizeMask) << shift);
	assign newLo = heldReq.addr[3] ? {merged[63:0], loLine[63:0]} : merged;
	assign newHi = heldReq.addr[3] ? {hiLine[127:64], merged[127:64]} : hiLine;

	assign doStore = heldReq.kind == kindStore && !stall;
	assign storeEven = '{enable: doStore && needEven, dirty: 1'b1, lineAddr: evenLine,
		data: heldReq.addr[4] ? newHi : newLo};
	assign storeOdd = '{enable: doStore && needOdd, dirty: 1'b1, lineAddr: oddLine,
		data: heldReq.addr[4] ? newLo : newHi};

	assign evenWrite = fillEven.enable ? fillEven : storeEven;	// fill wins
	assign oddWrite = fillOdd.enable ? fillOdd : storeOdd;

	always_ff @(posedge clock or negedge arstN)
	begin
		if (!arstN)
		begin
			lastEven <= '0;
			lastOdd <= '0;
			coreResp <= '0;
		end
		else
		begin
			lastEven <= evenWrite;
			lastOdd <= oddWrite;
			coreResp.valid <= active && !stall;
			coreResp.loadData <= (heldReq.kind == kindLoad) ? loadValue : '0;
		end
	end

	// while stalled the banks only take clean fills
	assert property (@(posedge clock) disable iff (!arstN)
		stall |-> !(evenWrite.enable && evenWrite.dirty) &&
			!(oddWrite.enable && oddWrite.dirty));

	// no response may complete a request that still misses
	assert property (@(posedge clock) disable iff (!arstN)
		(missEven || missOdd) |=> !coreResp.valid);

endmodule

//--- hw/missEngine.sv
`timescale 1ns/1ps

module missEngine
	import l1dPkg::*;
(
	input logic clock,
	input logic arstN,
	input logic missEven,
	input logic missOdd,
	input lineAddrT evenLine,
	input lineAddrT oddLine,
	input bankEntryT evenEntry,
	input bankEntryT oddEntry,
	input lineT memData,
	input memOkT memOk,
	output memReqT memReq,
	output bankWriteT fillEven,
	output bankWriteT fillOdd,
	output logic busy
);
	typedef enum logic [2:0] {idle, writeBack, fill, install, waitReady} stateT;

	stateT state;
	logic serveOdd;	// bank being refilled
	lineAddrT targetLine;
	lineT fillData;
	bankEntryT victim;
	bankWriteT installWrite;

	assign victim = serveOdd ? oddEntry : evenEntry;
	assign busy = state != idle;

	assign installWrite = '{enable: 1'b1, dirty: 1'b0, lineAddr: targetLine, data: fillData};
	assign fillEven = (state == install && !serveOdd) ? installWrite : '0;
	assign fillOdd = (state == install && serveOdd) ? installWrite : '0;

	always_ff @(posedge clock or negedge arstN)
	begin
		if (!arstN)
		begin
			state <= idle;
			serveOdd <= 1'b0;
			memReq <= '0;	// op idle
		end
		else
		begin
			case (state)
				idle:
					if (missEven || missOdd)
					begin
						serveOdd <= !missEven;	// even first
						state <= writeBack;
					end
				writeBack:
					// victim is read again by now, so a fresh store is seen
					if (memReq.op == opIdle)
					begin
						if (!(victim.valid && victim.dirty))
							state <= fill;
						else if (memOk == okReady)
							memReq <= '{op: opWriteLine, addr: {victim.lineAddr, 4'h0},
								data: victim.data};
					end
					else if (memOk == okOk)
					begin
						memReq.op <= opIdle;
						state <= fill;
					end
				fill:
					if (memReq.op == opIdle)
					begin
						if (memOk == okReady)	// wait out the previous op
							memReq <= '{op: opReadLine, addr: {targetLine, 4'h0}, data: '0};
					end
					else if (memOk == okOk)
					begin
						memReq.op <= opIdle;
						state <= install;
					end
				install:
					state <= waitReady;
				default:
					if (memOk == okReady)
						state <= idle;
			endcase
		end
	end

	always_ff @(posedge clock)
	begin
		if (state == idle)
			targetLine <= missEven ? evenLine : oddLine;
		if (state == fill && memReq.op == opReadLine && memOk == okOk)
			fillData <= memData;	// only valid in the ok cycle
	end

	// request must not move until the memory answers
	assert property (@(posedge clock) disable iff (!arstN)
		(memReq.op != opIdle && memOk != okOk) |=> $stable(memReq));

endmodule

//--- hw/l1dCache.sv
`timescale 1ns/1ps

module l1dCache
	import l1dPkg::*;
#(
	parameter int indexBits = 6
)(
	input logic clock,
	input logic arstN,
	input coreReqT coreReq,
	output logic ready,
	output coreRespT coreResp,
	output memReqT memReq,
	input lineT memData,
	input memOkT memOk
);
	coreReqT heldReq;
	lineAddrT evenLine;
	lineAddrT oddLine;
	lineAddrT readEven;
	lineAddrT readOdd;
	bankEntryT evenEntry;
	bankEntryT oddEntry;
	bankWriteT evenWrite;
	bankWriteT oddWrite;
	bankWriteT fillEven;
	bankWriteT fillOdd;
	logic missEven;
	logic missOdd;
	logic busy;
	logic stall;

	assign ready = ~stall;

	requestStage reqStage (.clock, .arstN, .coreReq, .stall, .heldReq,
		.evenLine, .oddLine, .readEven, .readOdd);

	// even lines in one bank, odd lines in the other
	cacheBank #(.indexBits(indexBits)) evenBank (.clock, .arstN,
		.readLine(readEven), .entry(evenEntry), .write(evenWrite));
	cacheBank #(.indexBits(indexBits)) oddBank (.clock, .arstN,
		.readLine(readOdd), .entry(oddEntry), .write(oddWrite));

	accessStage access (.clock, .arstN, .heldReq, .evenLine, .oddLine,
		.evenEntry, .oddEntry, .fillEven, .fillOdd, .busy, .missEven, .missOdd,
		.stall, .evenWrite, .oddWrite, .coreResp);

	missEngine miss (.clock, .arstN, .missEven, .missOdd, .evenLine, .oddLine,
		.evenEntry, .oddEntry, .memData, .memOk, .memReq, .fillEven, .fillOdd,
		.busy);

endmodule

//--- testbench/memoryModel.sv
`timescale 1ns/1ps

module memoryModel
	import l1dPkg::*;
(
	input logic clock,
	input logic arstN,
	input memReqT memReq,
	output memOkT memOk,
	output lineT memData,
	output int writeCount,
	output addrT lastWriteAddr,
	output lineT lastWriteLine
);
	logic [7:0] stored [addrT];	// bytes written back so far
	int holdLeft;

	// every byte of the address takes part
	function automatic logic [7:0] patternByte(addrT a);
		logic [7:0] folded;
		folded = a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24];
		return folded * 8'd37 + 8'd11;
	endfunction

	function automatic lineT readLine(addrT base);
		lineT line;
		for (int k = 0; k < 16; k++)
			line[8*k +: 8] = stored.exists(base + k) ? stored[base + k] : patternByte(base + k);
		return line;
	endfunction

	always @(posedge clock or negedge arstN)
	begin : answer
		logic go;
		int delay;
		addrT base;
		go = 1'b0;
		base = {memReq.addr[31:4], 4'h0};
		if (!arstN)
		begin
			memOk <= okReady;
			memData <= '0;
			holdLeft <= 0;
			writeCount <= 0;
			lastWriteAddr <= '0;
			lastWriteLine <= '0;
		end
		else if (memOk == okOk)
			memOk <= okReady;	// cache drops its op on this edge
		else if (memOk == okReady && memReq.op != opIdle)
		begin
			delay = int'($urandom % 6);
			if (delay == 0)
				go = 1'b1;
			else
			begin
				holdLeft <= delay - 1;
				memOk <= okHold;
			end
		end
		else if (memOk == okHold)
		begin
			if (holdLeft == 0)
				go = 1'b1;
			else
				holdLeft <= holdLeft - 1;
		end
		if (go)
		begin
			memOk <= okOk;
			if (memReq.op == opReadLine)
				memData <= readLine(base);	// only meaningful in the ok cycle
			else
			begin
				for (int k = 0; k < 16; k++)
					stored[base + k] = memReq.data[8*k +: 8];
				writeCount <= writeCount + 1;
				lastWriteAddr <= memReq.addr;
				lastWriteLine <= memReq.data;
			end
		end
	end

endmodule

//--- testbench/tbL1dCache.sv
`timescale 1ns/1ps

module tbL1dCache
	import l1dPkg::*;
();
	localparam int timeoutCycles = 200;

	logic clock;
	logic arstN;
	coreReqT coreReq;
	logic ready;
	coreRespT coreResp;
	memReqT memReq;
	lineT memData;
	memOkT memOk;
	int writeCount;
	addrT lastWriteAddr;
	lineT lastWriteLine;

	logic [7:0] shadow [addrT];	// bytes stored by the tests
	wordT expected [$];	// one entry per accepted request, in order
	string testName;
	int mismatches;
	int otherErrors;

	l1dCache #(.indexBits(4)) dut (.clock, .arstN, .coreReq, .ready, .coreResp,
		.memReq, .memData, .memOk);
	memoryModel mem (.clock, .arstN, .memReq, .memOk, .memData, .writeCount,
		.lastWriteAddr, .lastWriteLine);

	always #2 clock = ~clock;

	function automatic logic [7:0] patternByte(addrT a);
		logic [7:0] folded;
		folded = a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24];
		return folded * 8'd37 + 8'd11;
	endfunction

	function automatic logic [7:0] shadowByte(addrT a);
		return shadow.exists(a) ? shadow[a] : patternByte(a);
	endfunction

	function automatic int sizeBytes(accessSizeT size);
		return 1 << size;
	endfunction

	// little endian bytes, then sign or zero fill above the access size
	function automatic wordT expectLoad(addrT addr, accessSizeT size, logic isUnsigned);
		wordT value;
		int n;
		n = sizeBytes(size);
		value = '0;
		for (int k = 0; k < n; k++)
			value[8*k +: 8] = shadowByte(addr + k);
		if (!isUnsigned && n < 8 && value[8*n-1])
			for (int k = n; k < 8; k++)
				value[8*k +: 8] = 8'hff;
		return value;
	endfunction

	function automatic lineT shadowLine(addrT base);
		lineT line;
		for (int k = 0; k < 16; k++)
			line[8*k +: 8] = shadowByte(base + k);
		return line;
	endfunction

	task automatic checkWord(string what, wordT exp, wordT act);
		if (act !== exp)
		begin
			mismatches++;
			$display("Mismatch in %s, %s: expected %h, actual %h", testName, what, exp, act);
		end
	endtask

	task automatic checkLine(string what, lineT exp, lineT act);
		if (act !== exp)
		begin
			mismatches++;
			$display("Mismatch in %s, %s: expected %h, actual %h", testName, what, exp, act);
		end
	endtask

	task automatic checkAddr(string what, addrT exp, addrT act);
		if (act !== exp)
		begin
			mismatches++;
			$display("Mismatch in %s, %s: expected %h, actual %h", testName, what, exp, act);
		end
	endtask

	task automatic nextSlot();
		@(posedge clock);
		#1;
	endtask

	task automatic idleCore();
		coreReq.kind = kindNone;
	endtask

	// called 1 ns after an edge, returns 1 ns after the accepting edge
	task automatic sendRequest(accessKindT reqKind, accessSizeT reqSize, logic reqUnsigned,
		addrT reqAddr, wordT reqData);
		int waited;
		logic accepted;
		coreReq = '{kind: reqKind, size: reqSize, isUnsigned: reqUnsigned, addr: reqAddr,
			storeData: reqData};
		accepted = 1'b0;
		waited = 0;
		while (!accepted && waited < timeoutCycles)
		begin
			@(negedge clock);
			accepted = ready;	// stable mid cycle
			@(posedge clock);
			waited++;
		end
		#1;
		if (!accepted)
		begin
			otherErrors++;
			$display("Request to %h in %s was never accepted", reqAddr, testName);
			idleCore();
		end
		else if (reqKind == kindStore)
		begin
			for (int k = 0; k < sizeBytes(reqSize); k++)
				shadow[reqAddr + k] = reqData[8*k +: 8];
			expected.push_back('0);
		end
		else
			expected.push_back(expectLoad(reqAddr, reqSize, reqUnsigned));
	endtask

	task automatic waitResponses();
		int waited;
		waited = 0;
		while (expected.size() != 0 && waited < timeoutCycles)
		begin
			nextSlot();
			waited++;
		end
		if (expected.size() != 0)
		begin
			otherErrors++;
			$display("%0d responses never arrived in %s", expected.size(), testName);
			expected.delete();
		end
	endtask

	task automatic singleAccess(accessKindT reqKind, accessSizeT reqSize, logic reqUnsigned,
		addrT reqAddr, wordT reqData);
		sendRequest(reqKind, reqSize, reqUnsigned, reqAddr, reqData);
		idleCore();
		waitResponses();
	endtask

	// responses come back in request order
	always @(negedge clock)
	begin
		if (arstN && coreResp.valid)
		begin
			if (expected.size() == 0)
			begin
				otherErrors++;
				$display("Response without an outstanding request in %s", testName);
			end
			else
				checkWord("response data", expected.pop_front(), coreResp.loadData);
		end
	end

	task automatic testLoadSizes();
		accessSizeT sizeList [4];
		addrT addr;
		logic [7:0] topByte;
		sizeList = '{sizeByte, sizeHalf, sizeWord, sizeDouble};
		testName = "load sizes";
		for (int s = 0; s < 4; s++)
			for (int u = 0; u < 2; u++)
			begin
				addr = 32'h0000_0100 + addrT'(s * 32 + u * 16 + 16 - sizeBytes(sizeList[s]));
				topByte = shadowByte(addr + addrT'(sizeBytes(sizeList[s]) - 1));
				while (!topByte[7])
				begin
					addr += 32'h0000_0200;	// same index, new tag
					topByte = shadowByte(addr + addrT'(sizeBytes(sizeList[s]) - 1));
				end
				repeat (2)
					singleAccess(kindLoad, sizeList[s], u[0], addr, '0);	// miss, then hit
			end
	endtask

	task automatic testSpanning();
		addrT addr;
		testName = "line crossing";
		for (int par = 0; par < 2; par++)
			for (int ofs = 9; ofs < 16; ofs++)
			begin
				addr = 32'h0000_0400 + addrT'((ofs - 9) * 64 + par * 16 + ofs);
				singleAccess(kindLoad, sizeDouble, ofs[0], addr, '0);
				singleAccess(kindLoad, sizeWord, 1'b0, addr + 2, '0);
			end
	endtask

	task automatic testStoreForward();
		testName = "store forwarding";
		singleAccess(kindLoad, sizeDouble, 1'b1, 32'h0000_0600, '0);
		singleAccess(kindLoad, sizeDouble, 1'b1, 32'h0000_0610, '0);
		// each load goes out the cycle after its store
		sendRequest(kindStore, sizeWord, 1'b0, 32'h0000_0604, 64'h0123_4567_89ab_cdef);
		sendRequest(kindLoad, sizeWord, 1'b0, 32'h0000_0604, '0);
		sendRequest(kindStore, sizeByte, 1'b0, 32'h0000_0609, 64'h80);
		sendRequest(kindLoad, sizeByte, 1'b0, 32'h0000_0609, '0);
		sendRequest(kindStore, sizeDouble, 1'b0, 32'h0000_060d, 64'hfedc_ba98_7654_3210);
		sendRequest(kindLoad, sizeDouble, 1'b1, 32'h0000_060d, '0);
		sendRequest(kindLoad, sizeDouble, 1'b1, 32'h0000_0600, '0);	// neighbours
		sendRequest(kindLoad, sizeDouble, 1'b1, 32'h0000_0608, '0);
		sendRequest(kindLoad, sizeDouble, 1'b1, 32'h0000_0614, '0);
		idleCore();
		waitResponses();
	endtask

	task automatic testDirtyEviction();
		int writesBefore;
		testName = "dirty eviction";
		singleAccess(kindStore, sizeWord, 1'b0, 32'h0000_1004, 64'h0000_0000_9abc_def0);
		writesBefore = writeCount;
		singleAccess(kindLoad, sizeDouble, 1'b0, 32'h0000_1200, '0);	// same even index
		if (writeCount != writesBefore + 1)
		begin
			otherErrors++;
			$display("Eviction in %s wrote back %0d lines instead of one", testName,
				writeCount - writesBefore);
		end
		checkAddr("writeback address", 32'h0000_1000, lastWriteAddr);
		checkLine("writeback line", shadowLine(32'h0000_1000), lastWriteLine);
		singleAccess(kindLoad, sizeWord, 1'b0, 32'h0000_1004, '0);
	endtask

	task automatic testRandom();
		logic [31:0] r;
		testName = "random traffic";
		for (int i = 0; i < 200; i++)
		begin
			r = $urandom;
			sendRequest(r[0] ? kindStore : kindLoad, accessSizeT'(r[2:1]), r[3],
				32'h0000_2000 + {22'd0, r[31:22]}, {$urandom, $urandom});
			if (r[6:4] == 3'd0)
			begin
				idleCore();	// occasional gap
				repeat (int'(r[9:7]))
					nextSlot();
			end
		end
		idleCore();
		waitResponses();
	endtask

	initial
	begin
		void'($urandom(32'hfa63ab48));
		clock = 1'b0;
		arstN = 1'b0;
		coreReq = '0;
		mismatches = 0;
		otherErrors = 0;
		testName = "reset";
		repeat (16)
			@(posedge clock);
		#1;
		arstN = 1'b1;
		nextSlot();
		testLoadSizes();
		testSpanning();
		testStoreForward();
		testDirtyEviction();
		testRandom();
		$display("Errors: %0d mismatches, %0d other failures", mismatches, otherErrors);
		if (mismatches == 0 && otherErrors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

	initial
	begin
		#1_000_000;
		$display("Watchdog expired before the tests finished");
		$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

//--- list.f
hw/l1dPkg.sv
hw/requestStage.sv
hw/cacheBank.sv
hw/accessStage.sv
hw/missEngine.sv
hw/l1dCache.sv
testbench/memoryModel.sv
testbench/tbL1dCache.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= tbL1dCache
FILELIST ?= list.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert --timescale 1ns/1ps

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "ALL TESTS PASSED" $(LOG) || { echo "No verdict found in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
